//--- hdl/alu.sv
module alu (
    input  exec_pkg::word_t   src0,
    input  exec_pkg::word_t   src1,
    input  exec_pkg::alu_op_t aluop,
    output exec_pkg::word_t   result
);

    logic [4:0] shamt;

    assign shamt = src1[4:0];

    always_comb begin
        case (aluop)
            exec_pkg::alu_add: begin
                result = src0 + src1;
            end
            exec_pkg::alu_sub: begin
                result = src0 - src1;
            end
            exec_pkg::alu_and: begin
                result = src0 & src1;
            end
            exec_pkg::alu_or: begin
                result = src0 | src1;
            end
            exec_pkg::alu_xor: begin
                result = src0 ^ src1;
            end
            exec_pkg::alu_sll: begin
                result = src0 << shamt;
            end
            exec_pkg::alu_srl: begin
                result = src0 >> shamt;
            end
            exec_pkg::alu_sra: begin
                result = $signed(src0) >>> shamt;
            end
            exec_pkg::alu_slt: begin
                result = {31'b0, $signed(src0) < $signed(src1)};
            end
            exec_pkg::alu_sltu: begin
                result = {31'b0, src0 < src1};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

//--- hdl/branch_unit.sv
module branch_unit (
    input  exec_pkg::word_t      src0,
    input  exec_pkg::word_t      src1,
    input  exec_pkg::word_t      pc,
    input  exec_pkg::word_t      imm,
    input  exec_pkg::branch_op_t branchop,
    input  exec_pkg::jump_kind_t branchjump,
    output logic                 flag,
    output exec_pkg::word_t      pcnext
);

    exec_pkg::word_t jalr_target;

    always_comb begin
        case (branchop)
            exec_pkg::br_beq:  flag = src0 == src1;
            exec_pkg::br_bne:  flag = src0 != src1;
            exec_pkg::br_blt:  flag = $signed(src0) < $signed(src1);
            exec_pkg::br_bge:  flag = $signed(src0) >= $signed(src1);
            exec_pkg::br_bltu: flag = src0 < src1;
            exec_pkg::br_bgeu: flag = src0 >= src1;
            default:           flag = 1'b0;
        endcase
    end

    assign jalr_target = src0 + imm;

    // ------------------------------------------------------------------------
    // Next PC
    // ------------------------------------------------------------------------

    always_comb begin
        case (branchjump)
            exec_pkg::jump_branch: begin
                pcnext = flag ? pc + imm : pc + 32'd4;
            end
            exec_pkg::jump_jal: begin
                pcnext = pc + imm;
            end
            exec_pkg::jump_jalr: begin
                pcnext = {jalr_target[31:1], 1'b0};
            end
            default: begin
                pcnext = pc + 32'd4;
            end
        endcase
    end

endmodule

//--- hdl/exec.sv
module exec (
    input  logic                clk,
    input  logic                rst,
    input  logic                enable,
    output logic                fin,
    output exec_pkg::reg_addr_t rd,
    output logic                regwrite,
    output logic                memread,
    output logic                branchjump_miss,
    input  exec_pkg::word_t     rdata0,
    input  exec_pkg::word_t     rdata1,
    input  exec_pkg::inst_t     inst,
    output exec_pkg::word_t     pcnext,
    output exec_pkg::word_t     result,
    output exec_pkg::word_t     mem_addr
);

    exec_pkg::word_t src0;
    exec_pkg::word_t src1;
    exec_pkg::word_t alu_result;
    exec_pkg::word_t fpu_result;
    logic            fpu_fin;
    logic            taken;

    // ------------------------------------------------------------------------
    // Operand select
    // ------------------------------------------------------------------------

    always_comb begin
        case (inst.src0)
            exec_pkg::src0_reg: src0 = rdata0;
            exec_pkg::src0_pc:  src0 = inst.pc;
            default:            src0 = '0;
        endcase
    end

    always_comb begin
        case (inst.src1)
            exec_pkg::src1_reg:  src1 = rdata1;
            exec_pkg::src1_four: src1 = 32'd4;
            exec_pkg::src1_imm:  src1 = inst.imm;
            default:             src1 = '0;
        endcase
    end

    // ------------------------------------------------------------------------
    // Units
    // ------------------------------------------------------------------------

    alu alu_inst (
        .src0   (src0),
        .src1   (src1),
        .aluop  (inst.aluop),
        .result (alu_result)
    );

    // FPU works on the raw register operands.
    fpu fpu_inst (
        .clk    (clk),
        .rst    (rst),
        .start  (enable & inst.aluorfpu),
        .src0   (rdata0),
        .src1   (rdata1),
        .fpuop  (inst.fpuop),
        .result (fpu_result),
        .fin    (fpu_fin)
    );

    branch_unit branch_unit_inst (
        .src0       (rdata0),
        .src1       (rdata1),
        .pc         (inst.pc),
        .imm        (inst.imm),
        .branchop   (inst.branchop),
        .branchjump (inst.branchjump),
        .flag       (taken),
        .pcnext     (pcnext)
    );

    assign result = inst.aluorfpu ? fpu_result : alu_result;
    assign fin    = inst.aluorfpu ? fpu_fin : enable;

    // Branches are predicted not taken.
    always_comb begin
        case (inst.branchjump)
            exec_pkg::jump_branch: branchjump_miss = taken;
            exec_pkg::jump_jalr:   branchjump_miss = 1'b1;
            default:               branchjump_miss = 1'b0;
        endcase
    end

    assign mem_addr = rdata0 + inst.imm;
    assign rd       = inst.rd;
    assign regwrite = inst.regwrite;
    assign memread  = inst.memread;

endmodule

//--- hdl/exec_pkg.sv
package exec_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------

    typedef logic [31:0] word_t;

    // Entries 0 to 31 are integer registers, 32 to 63 are float registers.
    typedef logic [5:0] reg_addr_t;

    // ------------------------------------------------------------------------
    // Operation encodings
    // ------------------------------------------------------------------------

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu
    } alu_op_t;

    typedef enum logic [2:0] {
        fpu_fmul, fpu_fsgnj, fpu_fsgnjn, fpu_fsgnjx,
        fpu_feq, fpu_flt, fpu_fle, fpu_fmv
    } fpu_op_t;

    typedef enum logic [2:0] {
        br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu
    } branch_op_t;

    typedef enum logic [1:0] {
        jump_none   = 2'b00,
        jump_branch = 2'b01,
        jump_jal    = 2'b10,
        jump_jalr   = 2'b11
    } jump_kind_t;

    typedef enum logic [1:0] {src0_reg, src0_zero, src0_pc} src0_sel_t;

    typedef enum logic [1:0] {src1_reg, src1_four, src1_imm} src1_sel_t;

    // Decoded instruction.
    typedef struct packed {
        word_t      pc;
        word_t      imm;
        reg_addr_t  rs0;
        reg_addr_t  rs1;
        reg_addr_t  rd;
        src0_sel_t  src0;
        src1_sel_t  src1;
        alu_op_t    aluop;
        fpu_op_t    fpuop;
        branch_op_t branchop;
        jump_kind_t branchjump;
        logic       aluorfpu;
        logic       regwrite;
        logic       memread;
    } inst_t;

endpackage

//--- hdl/exec_top.sv
module exec_top #(
    parameter int num_regs = 64
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                enable,
    input  exec_pkg::inst_t     inst,
    input  logic                load_en,
    input  exec_pkg::reg_addr_t load_addr,
    input  exec_pkg::word_t     load_data,
    output logic                fin,
    output exec_pkg::word_t     result,
    output exec_pkg::word_t     pcnext,
    output logic                branchjump_miss,
    output exec_pkg::word_t     mem_addr,
    output logic                memread
);

    exec_pkg::word_t     rdata0;
    exec_pkg::word_t     rdata1;
    exec_pkg::reg_addr_t rd;
    logic                regwrite;
    logic                wb_en;
    logic                we;
    exec_pkg::reg_addr_t waddr;
    exec_pkg::word_t     wdata;

    // Writeback wins over the load port.
    assign wb_en = fin & regwrite & (rd != '0);
    assign we    = wb_en | load_en;
    assign waddr = wb_en ? rd : load_addr;
    assign wdata = wb_en ? result : load_data;

    regfile #(
        .num_regs (num_regs)
    ) regfile_inst (
        .clk    (clk),
        .rst    (rst),
        .raddr0 (inst.rs0),
        .raddr1 (inst.rs1),
        .rdata0 (rdata0),
        .rdata1 (rdata1),
        .we     (we),
        .waddr  (waddr),
        .wdata  (wdata)
    );

    exec exec_inst (
        .clk             (clk),
        .rst             (rst),
        .enable          (enable),
        .fin             (fin),
        .rd              (rd),
        .regwrite        (regwrite),
        .memread         (memread),
        .branchjump_miss (branchjump_miss),
        .rdata0          (rdata0),
        .rdata1          (rdata1),
        .inst            (inst),
        .pcnext          (pcnext),
        .result          (result),
        .mem_addr        (mem_addr)
    );

endmodule

//--- hdl/float_pkg.sv
package float_pkg;

    // ------------------------------------------------------------------------
    // Single precision fields
    // ------------------------------------------------------------------------

    typedef logic [7:0] exp_t;

    typedef logic [22:0] frac_t;

    // Fraction with the hidden one in front.
    typedef logic [23:0] mant_t;

    typedef struct packed {
        logic  sign;
        exp_t  exp;
        frac_t frac;
    } float_t;

endpackage

//--- hdl/fpu.sv
module fpu (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  exec_pkg::word_t   src0,
    input  exec_pkg::word_t   src1,
    input  exec_pkg::fpu_op_t fpuop,
    output exec_pkg::word_t   result,
    output logic              fin
);

    typedef enum logic [1:0] {st_idle, st_mult, st_norm, st_done} state_t;

    state_t            state;
    logic [4:0]        step;
    logic [47:0]       acc;
    logic [47:0]       mcand;
    float_pkg::mant_t  mplier;
    logic              prod_sign;
    logic signed [9:0] prod_exp;
    logic              prod_zero;

    float_pkg::float_t fa;
    float_pkg::float_t fb;
    logic              both_zero;
    logic              is_eq;
    logic              is_lt;
    exec_pkg::word_t   quick_result;
    float_pkg::frac_t  norm_frac;
    logic signed [9:0] norm_exp;

    assign fa = src0;
    assign fb = src1;

    // ------------------------------------------------------------------------
    // Single-cycle operations
    // ------------------------------------------------------------------------

    // +0 and -0 compare equal.
    assign both_zero = (fa.exp == '0) && (fa.frac == '0) && (fb.exp == '0) && (fb.frac == '0);
    assign is_eq = both_zero || (src0 == src1);

    always_comb begin
        if (both_zero) begin
            is_lt = 1'b0;
        end else if (fa.sign != fb.sign) begin
            is_lt = fa.sign;
        end else if (!fa.sign) begin
            is_lt = src0[30:0] < src1[30:0];
        end else begin
            is_lt = src0[30:0] > src1[30:0];
        end
    end

    always_comb begin
        case (fpuop)
            exec_pkg::fpu_fsgnj:  quick_result = {fb.sign, src0[30:0]};
            exec_pkg::fpu_fsgnjn: quick_result = {~fb.sign, src0[30:0]};
            exec_pkg::fpu_fsgnjx: quick_result = {fa.sign ^ fb.sign, src0[30:0]};
            exec_pkg::fpu_feq:    quick_result = {31'b0, is_eq};
            exec_pkg::fpu_flt:    quick_result = {31'b0, is_lt};
            exec_pkg::fpu_fle:    quick_result = {31'b0, is_lt | is_eq};
            default:              quick_result = src0;
        endcase
    end

    // ------------------------------------------------------------------------
    // Multiply
    // ------------------------------------------------------------------------

    always_comb begin
        if (acc[47]) begin
            norm_frac = acc[46:24];
            norm_exp  = prod_exp + 10'sd1;
        end else begin
            norm_frac = acc[45:23];
            norm_exp  = prod_exp;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            step  <= '0;
            fin   <= 1'b0;
        end else begin
            fin <= 1'b0;
            case (state)
                st_idle, st_done: begin
                    state <= st_idle;
                    if (start) begin
                        if (fpuop == exec_pkg::fpu_fmul) begin
                            state <= st_mult;
                            step  <= '0;
                        end else begin
                            fin <= 1'b1;
                        end
                    end
                end
                st_mult: begin
                    step <= step + 5'd1;
                    // One multiplier bit per cycle.
                    if (step == 5'd23) begin
                        state <= st_norm;
                    end
                end
                st_norm: begin
                    state <= st_done;
                    fin   <= 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            st_idle, st_done: begin
                if (start) begin
                    result    <= quick_result;
                    acc       <= '0;
                    mcand     <= {24'b0, 1'b1, fa.frac};
                    mplier    <= {1'b1, fb.frac};
                    prod_sign <= fa.sign ^ fb.sign;
                    prod_exp  <= $signed({2'b00, fa.exp}) + $signed({2'b00, fb.exp}) - 10'sd127;
                    prod_zero <= (fa.exp == '0) || (fb.exp == '0);
                end
            end
            st_mult: begin
                if (mplier[0]) begin
                    acc <= acc + mcand;
                end
                mcand  <= mcand << 1;
                mplier <= mplier >> 1;
            end
            st_norm: begin
                // Truncate, and flush on underflow or a zero input exponent.
                if (prod_zero || norm_exp <= 10'sd0) begin
                    result <= {prod_sign, 31'b0};
                end else begin
                    result <= {prod_sign, norm_exp[7:0], norm_frac};
                end
            end
        endcase
    end

endmodule

//--- hdl/regfile.sv
module regfile #(
    parameter int num_regs = 64
) (
    input  logic                clk,
    input  logic                rst,
    input  exec_pkg::reg_addr_t raddr0,
    input  exec_pkg::reg_addr_t raddr1,
    output exec_pkg::word_t     rdata0,
    output exec_pkg::word_t     rdata1,
    input  logic                we,
    input  exec_pkg::reg_addr_t waddr,
    input  exec_pkg::word_t     wdata
);

    exec_pkg::word_t regs [num_regs];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Entry 0 is hardwired to zero on the read side.
    assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the exec_tb simulation with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module exec_tb -f verilog.f -o exec_sim > build.log 2>&1 \
    && ./obj_dir/exec_sim > sim.log 2>&1 \
    || { cat build.log; echo "build or simulation run failed"; exit 1; }

cat sim.log
grep -qx "Testbench passed" sim.log && exit 0 || exit 1

//--- testbench/exec_checker.sv
module exec_checker (
    input  logic                clk,
    input  logic                rst,
    input  exec_pkg::inst_t     inst,
    input  logic                load_en,
    input  exec_pkg::reg_addr_t load_addr,
    input  exec_pkg::word_t     load_data,
    input  logic                fin,
    input  exec_pkg::word_t     result,
    input  exec_pkg::word_t     pcnext,
    input  logic                branchjump_miss,
    input  exec_pkg::word_t     mem_addr,
    input  logic                memread,
    output int                  errors
);

    typedef struct packed {
        exec_pkg::word_t result;
        exec_pkg::word_t pcnext;
        logic            miss;
        exec_pkg::word_t mem_addr;
        logic            memread;
    } expect_t;

    exec_pkg::word_t shadow [64];

    function automatic exec_pkg::word_t read_shadow(input exec_pkg::reg_addr_t a);
        return (a == 6'd0) ? 32'd0 : shadow[a];
    endfunction

    // Maps a float onto an unsigned key with the same order.
    function automatic exec_pkg::word_t order_key(input exec_pkg::word_t x);
        return x[31] ? ~x : (x | 32'h8000_0000);
    endfunction

    function automatic exec_pkg::word_t fmul_ref(input exec_pkg::word_t a, input exec_pkg::word_t b);
        float_pkg::float_t fa;
        float_pkg::float_t fb;
        logic [47:0]       p;
        int                e;
        logic              s;
        float_pkg::frac_t  f;
        fa = a;
        fb = b;
        s = fa.sign ^ fb.sign;
        if (fa.exp == 8'd0 || fb.exp == 8'd0) begin
            return {s, 31'b0};
        end
        p = {24'b0, 1'b1, fa.frac} * {24'b0, 1'b1, fb.frac};
        e = int'(fa.exp) + int'(fb.exp) - 127;
        if (p[47]) begin
            f = p[46:24];
            e++;
        end else begin
            f = p[45:23];
        end
        if (e <= 0) begin
            return {s, 31'b0};
        end
        return {s, e[7:0], f};
    endfunction

    function automatic exec_pkg::word_t alu_ref(input exec_pkg::alu_op_t op,
                                                input exec_pkg::word_t a,
                                                input exec_pkg::word_t b);
        case (op)
            exec_pkg::alu_add:  return a + b;
            exec_pkg::alu_sub:  return a - b;
            exec_pkg::alu_and:  return a & b;
            exec_pkg::alu_or:   return a | b;
            exec_pkg::alu_xor:  return a ^ b;
            exec_pkg::alu_sll:  return a << b[4:0];
            exec_pkg::alu_srl:  return a >> b[4:0];
            exec_pkg::alu_sra:  return $signed(a) >>> b[4:0];
            exec_pkg::alu_slt:  return {31'b0, $signed(a) < $signed(b)};
            exec_pkg::alu_sltu: return {31'b0, a < b};
            default:            return 32'd0;
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------

    function automatic expect_t reference(input exec_pkg::inst_t i,
                                          input exec_pkg::word_t r0,
                                          input exec_pkg::word_t r1);
        expect_t         e;
        exec_pkg::word_t a;
        exec_pkg::word_t b;
        logic            taken;
        logic            eq;
        logic            lt;
        case (i.src0)
            exec_pkg::src0_reg: a = r0;
            exec_pkg::src0_pc:  a = i.pc;
            default:            a = 32'd0;
        endcase
        case (i.src1)
            exec_pkg::src1_reg:  b = r1;
            exec_pkg::src1_four: b = 32'd4;
            exec_pkg::src1_imm:  b = i.imm;
            default:             b = 32'd0;
        endcase
        case (i.branchop)
            exec_pkg::br_beq:  taken = r0 == r1;
            exec_pkg::br_bne:  taken = r0 != r1;
            exec_pkg::br_blt:  taken = $signed(r0) < $signed(r1);
            exec_pkg::br_bge:  taken = $signed(r0) >= $signed(r1);
            exec_pkg::br_bltu: taken = r0 < r1;
            exec_pkg::br_bgeu: taken = r0 >= r1;
            default:           taken = 1'b0;
        endcase
        // Signed zeros are equal.
        eq = (r0 == r1) || (r0[30:0] == 31'd0 && r1[30:0] == 31'd0);
        lt = !eq && (order_key(r0) < order_key(r1));
        if (i.aluorfpu) begin
            case (i.fpuop)
                exec_pkg::fpu_fmul:   e.result = fmul_ref(r0, r1);
                exec_pkg::fpu_fsgnj:  e.result = {r1[31], r0[30:0]};
                exec_pkg::fpu_fsgnjn: e.result = {~r1[31], r0[30:0]};
                exec_pkg::fpu_fsgnjx: e.result = {r0[31] ^ r1[31], r0[30:0]};
                exec_pkg::fpu_feq:    e.result = {31'b0, eq};
                exec_pkg::fpu_flt:    e.result = {31'b0, lt};
                exec_pkg::fpu_fle:    e.result = {31'b0, lt | eq};
                default:              e.result = r0;
            endcase
        end else begin
            e.result = alu_ref(i.aluop, a, b);
        end
        case (i.branchjump)
            exec_pkg::jump_branch: begin
                e.pcnext = taken ? i.pc + i.imm : i.pc + 32'd4;
                e.miss   = taken;
            end
            exec_pkg::jump_jal: begin
                e.pcnext = i.pc + i.imm;
                e.miss   = 1'b0;
            end
            exec_pkg::jump_jalr: begin
                e.pcnext = (r0 + i.imm) & ~32'd1;
                e.miss   = 1'b1;
            end
            default: begin
                e.pcnext = i.pc + 32'd4;
                e.miss   = 1'b0;
            end
        endcase
        e.mem_addr = r0 + i.imm;
        e.memread  = i.memread;
        return e;
    endfunction

    function automatic string test_name(input exec_pkg::inst_t i);
        if (i.aluorfpu) begin
            return i.fpuop.name();
        end
        case (i.branchjump)
            exec_pkg::jump_branch: return i.branchop.name();
            exec_pkg::jump_none:   return i.aluop.name();
            default:               return i.branchjump.name();
        endcase
    endfunction

    task automatic check(input string name, input string what,
                         input exec_pkg::word_t exp, input exec_pkg::word_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s %s: expected %h, actual %h", name, what, exp, act);
            errors++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Compare on fin
    // ------------------------------------------------------------------------

    always @(posedge clk) begin : compare
        exec_pkg::word_t r0;
        exec_pkg::word_t r1;
        expect_t         e;
        if (rst) begin
            errors = 0;
            for (int k = 0; k < 64; k++) begin
                shadow[k] = 32'd0;
            end
        end else begin
            r0 = read_shadow(inst.rs0);
            r1 = read_shadow(inst.rs1);
            e  = reference(inst, r0, r1);
            if (fin) begin
                check(test_name(inst), "result", e.result, result);
                check(test_name(inst), "pcnext", e.pcnext, pcnext);
                check(test_name(inst), "miss", {31'b0, e.miss}, {31'b0, branchjump_miss});
                check(test_name(inst), "mem_addr", e.mem_addr, mem_addr);
                check(test_name(inst), "memread", {31'b0, e.memread}, {31'b0, memread});
            end
            if (fin && inst.regwrite && inst.rd != 6'd0) begin
                shadow[inst.rd] = e.result;
            end else if (load_en) begin
                shadow[load_addr] = load_data;
            end
        end
    end

endmodule

//--- testbench/exec_tb.sv
module exec_tb;

    localparam int alu_tests   = 40;
    localparam int fp_tests    = 28;
    localparam int mul_tests   = 16;
    localparam int num_tests   = alu_tests + 18 + 4 + fp_tests + mul_tests + 4;
    localparam int cycle_limit = num_tests * 40 + 200;
    localparam int fin_limit   = 40;

    logic                clk;
    logic                rst;
    logic                enable;
    exec_pkg::inst_t     inst;
    logic                load_en;
    exec_pkg::reg_addr_t load_addr;
    exec_pkg::word_t     load_data;
    logic                fin;
    exec_pkg::word_t     result;
    exec_pkg::word_t     pcnext;
    logic                branchjump_miss;
    exec_pkg::word_t     mem_addr;
    logic                memread;

    int              check_errors;
    int              fin_errors  = 0;
    int              cycle_count = 0;
    exec_pkg::word_t rng;
    exec_pkg::word_t shadow [64];

    tb_clock #(.period(100)) tb_clock_inst (.clk(clk));

    exec_top #(
        .num_regs (64)
    ) exec_top_inst (
        .clk             (clk),
        .rst             (rst),
        .enable          (enable),
        .inst            (inst),
        .load_en         (load_en),
        .load_addr       (load_addr),
        .load_data       (load_data),
        .fin             (fin),
        .result          (result),
        .pcnext          (pcnext),
        .branchjump_miss (branchjump_miss),
        .mem_addr        (mem_addr),
        .memread         (memread)
    );

    exec_checker exec_checker_inst (
        .clk             (clk),
        .rst             (rst),
        .inst            (inst),
        .load_en         (load_en),
        .load_addr       (load_addr),
        .load_data       (load_data),
        .fin             (fin),
        .result          (result),
        .pcnext          (pcnext),
        .branchjump_miss (branchjump_miss),
        .mem_addr        (mem_addr),
        .memread         (memread),
        .errors          (check_errors)
    );

    function automatic exec_pkg::word_t xorshift(input exec_pkg::word_t x);
        exec_pkg::word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic exec_pkg::word_t next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    task automatic load_reg(input exec_pkg::reg_addr_t addr, input exec_pkg::word_t data);
        @(negedge clk);
        load_en   = 1'b1;
        load_addr = addr;
        load_data = data;
        shadow[addr] = data;
    endtask

    // Issue one instruction and wait for fin.
    task automatic run_inst(input exec_pkg::inst_t i);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        @(negedge clk);
        load_en = 1'b0;
        inst    = i;
        enable  = 1'b1;
        while (!seen && waited < fin_limit) begin
            @(posedge clk);
            waited++;
            if (fin) begin
                seen = 1'b1;
            end
            @(negedge clk);
            enable = 1'b0;
        end
        if (!seen) begin
            $display("ERROR: no fin within %0d cycles of enable (pc %h)", fin_limit, i.pc);
            fin_errors++;
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("ERROR: run stopped at the cycle limit of %0d", cycle_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin : stimulus
        exec_pkg::inst_t     i;
        exec_pkg::reg_addr_t a;
        exec_pkg::reg_addr_t b;
        exec_pkg::word_t     r;
        exec_pkg::word_t     fval;
        rst       = 1'b1;
        enable    = 1'b0;
        inst      = '0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        rng       = 32'd25;
        for (int k = 0; k < 64; k++) begin
            shadow[k] = 32'd0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // --------------------------------------------------------------------
        // Preload. Floats 56 to 62 have small exponents, 63 holds -0.
        // --------------------------------------------------------------------
        for (int k = 1; k < 64; k++) begin
            r = next_rand();
            if (k < 32) begin
                fval = r;
            end else if (k == 63) begin
                fval = 32'h8000_0000;
            end else if (k >= 56) begin
                fval = {r[31], 8'(1 + r[30:23] % 30), r[22:0]};
            end else begin
                fval = {r[31], 8'(100 + r[30:23] % 56), r[22:0]};
            end
            load_reg(6'(k), fval);
        end

        for (int n = 0; n < alu_tests; n++) begin
            i = '0;
            i.aluop = exec_pkg::alu_op_t'(4'(next_rand() % 10));
            i.src0  = exec_pkg::src0_sel_t'(2'(next_rand() % 3));
            i.src1  = exec_pkg::src1_sel_t'(2'(next_rand() % 3));
            r = next_rand();
            i.rs0 = {1'b0, r[4:0]};
            i.rs1 = {1'b0, r[9:5]};
            i.rd  = {1'b0, r[14:10]};
            i.memread = r[15];
            i.imm = next_rand();
            i.pc  = next_rand() & 32'hffff_fffc;
            run_inst(i);
        end

        // Pairs (a,b), (b,a) and (a,a) make each branch go both ways.
        a = {1'b0, 5'(1 + next_rand() % 31)};
        b = a;
        while (b == a || shadow[b] == shadow[a]) begin
            b = {1'b0, 5'(1 + next_rand() % 31)};
        end
        for (int op = 0; op < 6; op++) begin
            for (int p = 0; p < 3; p++) begin
                i = '0;
                i.branchjump = exec_pkg::jump_branch;
                i.branchop   = exec_pkg::branch_op_t'(3'(op));
                i.rs0 = (p == 1) ? b : a;
                i.rs1 = (p == 0) ? b : a;
                i.pc  = next_rand() & 32'h0000_fffc;
                i.imm = next_rand() & 32'h0000_0ffe;
                run_inst(i);
            end
        end

        for (int n = 0; n < 4; n++) begin
            i = '0;
            i.branchjump = (n < 2) ? exec_pkg::jump_jal : exec_pkg::jump_jalr;
            i.src0 = exec_pkg::src0_pc;
            i.src1 = exec_pkg::src1_four;
            i.rs0  = {1'b0, 5'(next_rand() % 32)};
            i.pc   = next_rand() & 32'h0000_fffc;
            i.imm  = next_rand() & 32'h0000_0fff;
            run_inst(i);
        end

        // --------------------------------------------------------------------
        // Float operations
        // --------------------------------------------------------------------
        for (int n = 0; n < fp_tests; n++) begin
            i = '0;
            i.aluorfpu = 1'b1;
            i.fpuop    = exec_pkg::fpu_op_t'(3'(1 + n / 4));
            r = next_rand();
            i.rs0 = {1'b1, r[4:0]};
            i.rs1 = {1'b1, r[9:5]};
            if (n % 4 == 0) begin
                i.rs1 = i.rs0;
            end else if (n % 4 == 1) begin
                // -0 against the +0 of register 0.
                i.rs0 = 6'd63;
                i.rs1 = 6'd0;
            end
            run_inst(i);
        end

        for (int n = 0; n < mul_tests; n++) begin
            i = '0;
            i.aluorfpu = 1'b1;
            i.fpuop    = exec_pkg::fpu_fmul;
            r = next_rand();
            i.rs0 = (n == 0) ? 6'd56 : {1'b1, r[4:0]};
            i.rs1 = (n == 0) ? 6'd57 : {1'b1, r[9:5]};
            run_inst(i);
        end

        // Writeback chain, with one write aimed at register 0.
        i = '0;
        i.src1 = exec_pkg::src1_imm;
        i.rs0 = 6'd1;
        i.imm = 32'd100;
        i.regwrite = 1'b1;
        i.rd = 6'd5;
        run_inst(i);
        i = '0;
        i.rs0 = 6'd5;
        i.rs1 = 6'd5;
        i.regwrite = 1'b1;
        i.rd = 6'd6;
        run_inst(i);
        i = '0;
        i.rs0 = 6'd1;
        i.rs1 = 6'd2;
        i.regwrite = 1'b1;
        i.rd = 6'd0;
        run_inst(i);
        i = '0;
        i.rs0 = 6'd0;
        i.rs1 = 6'd6;
        i.regwrite = 1'b1;
        i.rd = 6'd7;
        run_inst(i);

        repeat (4) @(posedge clk);
        $display("errors: %0d mismatches, %0d missing fin", check_errors, fin_errors);
        if (check_errors == 0 && fin_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- testbench/tb_clock.sv
module tb_clock #(
    parameter int period = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

endmodule

//--- verilog.f
hdl/exec_pkg.sv
hdl/float_pkg.sv
hdl/regfile.sv
hdl/alu.sv
hdl/fpu.sv
hdl/branch_unit.sv
hdl/exec.sv
hdl/exec_top.sv
testbench/tb_clock.sv
testbench/exec_checker.sv
testbench/exec_tb.sv
